//--- project.f
rtl/bus_pkg.sv
rtl/periph_regs_pkg.sv
rtl/gpi_sync.sv
rtl/gpio_port.sv
rtl/pwm_gen.sv
rtl/periph_router.sv
rtl/periph_top.sv
testbench/periph_chk.sv
testbench/tb_periph_top.sv

//--- Makefile
# Verilator build, run, lint and clean

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

VERILATOR ?= verilator
TOP       ?= tb_periph_top
RTL_TOP   ?= periph_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS := rtl/bus_pkg.sv rtl/periph_regs_pkg.sv rtl/gpi_sync.sv rtl/gpio_port.sv \
            rtl/pwm_gen.sv rtl/periph_router.sv rtl/periph_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_periph_top.sv
// ############################
// random accesses from a 32-bit lfsr, fixed seed
// checks rd_o, pins and pwm_o in the middle of each cycle
// stops at the first mismatch
// ############################
`default_nettype none

module tb_periph_top;

    localparam int GPIO_A_W     = 8;
    localparam int GPIO_B_W     = 16;
    localparam int RESET_CYCLES = 10;
    localparam int CNT_W        = periph_regs_pkg::PWM_CNT_W;

    // test lengths in loop iterations
    localparam int N_GPIO_WR = 40;
    localparam int N_GPI     = 20;
    localparam int N_UNMAP   = 30;
    localparam int N_PWM     = 200;
    localparam int N_MIX     = 500;

    // cycles per test, one access per cycle
    localparam int T1_CYC = 2 + 12;
    localparam int T2_CYC = N_GPIO_WR * 2;
    localparam int T3_CYC = N_GPI * 7;
    localparam int T4_CYC = N_UNMAP * 2;
    localparam int T5_CYC = 3 + N_PWM + 1 + 4;
    localparam int T6_CYC = N_MIX;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + T1_CYC + T2_CYC + T3_CYC + T4_CYC
                                  + T5_CYC + T6_CYC + 100;  // margin

    logic                       clk;
    logic                       resetn;
    bus_pkg::bus_req_t          bus;
    logic   [31 : 0]            rd;
    logic   [GPIO_A_W-1 : 0]    gpi_a;
    logic   [GPIO_A_W-1 : 0]    gpo_a;
    logic   [GPIO_A_W-1 : 0]    gpd_a;
    logic   [GPIO_B_W-1 : 0]    gpi_b;
    logic   [GPIO_B_W-1 : 0]    gpo_b;
    logic   [GPIO_B_W-1 : 0]    gpd_b;
    logic                       pwm;

    logic   [GPIO_A_W-1 : 0]    pin_a_next;     // pin values for the next access
    logic   [GPIO_B_W-1 : 0]    pin_b_next;
    logic   [31 : 0]            lfsr_state;
    int                         err_count;

    // register model
    logic   [GPIO_A_W-1 : 0]    m_gpo_a;
    logic   [GPIO_A_W-1 : 0]    m_gpd_a;
    logic   [GPIO_A_W-1 : 0]    m_sa1;          // first sync stage, port a
    logic   [GPIO_A_W-1 : 0]    m_sa2;          // readable stage
    logic   [GPIO_B_W-1 : 0]    m_gpo_b;
    logic   [GPIO_B_W-1 : 0]    m_gpd_b;
    logic   [GPIO_B_W-1 : 0]    m_sb1;
    logic   [GPIO_B_W-1 : 0]    m_sb2;
    logic   [CNT_W-1 : 0]       m_period;
    logic   [CNT_W-1 : 0]       m_duty;
    logic   [CNT_W-1 : 0]       m_cnt;
    logic                       m_en;
    logic                       pend_we;        // write still to land at next edge
    logic   [31 : 0]            pend_addr;
    logic   [31 : 0]            pend_wd;

    periph_top
    #(
        .GPIO_A_W   ( GPIO_A_W  ),
        .GPIO_B_W   ( GPIO_B_W  )
    )
    UUT
    (
        .clk        ( clk       ),
        .resetn     ( resetn    ),
        .bus_i      ( bus       ),
        .rd_o       ( rd        ),
        .gpi_a_i    ( gpi_a     ),
        .gpo_a_o    ( gpo_a     ),
        .gpd_a_o    ( gpd_a     ),
        .gpi_b_i    ( gpi_b     ),
        .gpo_b_o    ( gpo_b     ),
        .gpd_b_o    ( gpd_b     ),
        .pwm_o      ( pwm       )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function logic [31 : 0] rand_bits(input int n);
        logic fb;
        rand_bits = '0;
        for( int i = 0; i < n; i++ )
        begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30 : 0], fb};
            rand_bits  = {rand_bits[30 : 0], fb};
        end
    endfunction

    function logic [31 : 0] make_addr(input logic [3 : 0] sel, input logic [3 : 0] ofs);
        make_addr = {20'h00000, sel, 4'h0, ofs};
    endfunction

    // expected read word from the model
    function logic [31 : 0] model_read(input logic [31 : 0] addr);
        logic [3 : 0] sel;
        logic [3 : 0] ofs;
        sel        = addr[bus_pkg::SEL_LSB +: bus_pkg::SEL_W];
        ofs        = addr[bus_pkg::OFS_W-1 : 0];
        model_read = '0;
        if( sel == bus_pkg::SEL_GPIO_A )
        begin
            if( ofs == periph_regs_pkg::GPIO_GPO )      model_read[7 : 0] = m_gpo_a;
            else if( ofs == periph_regs_pkg::GPIO_DIR ) model_read[7 : 0] = m_gpd_a;
            else                                        model_read[7 : 0] = m_sa2;
        end
        else if( sel == bus_pkg::SEL_GPIO_B )
        begin
            if( ofs == periph_regs_pkg::GPIO_GPO )      model_read[15 : 0] = m_gpo_b;
            else if( ofs == periph_regs_pkg::GPIO_DIR ) model_read[15 : 0] = m_gpd_b;
            else                                        model_read[15 : 0] = m_sb2;
        end
        else if( sel == bus_pkg::SEL_PWM )
        begin
            case( ofs )
                periph_regs_pkg::PWM_PERIOD : model_read[CNT_W-1 : 0] = m_period;
                periph_regs_pkg::PWM_DUTY   : model_read[CNT_W-1 : 0] = m_duty;
                periph_regs_pkg::PWM_CTRL   : model_read[0]           = m_en;
                periph_regs_pkg::PWM_CNT    : model_read[CNT_W-1 : 0] = m_cnt;
                default                     : model_read              = '0;
            endcase
        end
    endfunction

    // one clock edge of the model, old register values first
    task model_step();
        logic [3 : 0] sel;
        logic [3 : 0] ofs;
        if( !m_en )
            m_cnt = '0;
        else if( m_cnt >= m_period )
            m_cnt = '0;     // wrap after period
        else
            m_cnt = m_cnt + 1'b1;
        m_sa2 = m_sa1;
        m_sa1 = gpi_a;      // pin value before the edge
        m_sb2 = m_sb1;
        m_sb1 = gpi_b;
        sel = pend_addr[bus_pkg::SEL_LSB +: bus_pkg::SEL_W];
        ofs = pend_addr[bus_pkg::OFS_W-1 : 0];
        if( pend_we && sel == bus_pkg::SEL_GPIO_A )
        begin
            case( ofs )
                periph_regs_pkg::GPIO_GPO : m_gpo_a = pend_wd[7 : 0];
                periph_regs_pkg::GPIO_DIR : m_gpd_a = pend_wd[7 : 0];
                default                   : ;
            endcase
        end
        if( pend_we && sel == bus_pkg::SEL_GPIO_B )
        begin
            case( ofs )
                periph_regs_pkg::GPIO_GPO : m_gpo_b = pend_wd[15 : 0];
                periph_regs_pkg::GPIO_DIR : m_gpd_b = pend_wd[15 : 0];
                default                   : ;
            endcase
        end
        if( pend_we && sel == bus_pkg::SEL_PWM )
        begin
            case( ofs )
                periph_regs_pkg::PWM_PERIOD : m_period = pend_wd[CNT_W-1 : 0];
                periph_regs_pkg::PWM_DUTY   : m_duty   = pend_wd[CNT_W-1 : 0];
                periph_regs_pkg::PWM_CTRL   : m_en     = pend_wd[0];
                default                     : ;     // cnt is read only
            endcase
        end
    endtask

    task check_word(input string name, input logic [31 : 0] exp, input logic [31 : 0] act);
        if( act !== exp )
        begin
            err_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task check_pins(input string name, input logic [15 : 0] exp, input logic [15 : 0] act);
        if( act !== exp )
        begin
            err_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task check_level(input string name, input logic exp, input logic act);
        if( act !== exp )
        begin
            err_count++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // drive one access at the edge, check everything mid-cycle
    task do_access(input string name, input logic [31 : 0] addr, input logic we,
                   input logic [31 : 0] wd);
        @(posedge clk);
        model_step();
        bus   <= {addr, we, wd};
        gpi_a <= pin_a_next;
        gpi_b <= pin_b_next;
        pend_we   = we;
        pend_addr = addr;
        pend_wd   = wd;
        @(negedge clk);
        check_word({name, " rd"}, model_read(addr), rd);
        check_pins({name, " gpo_a"}, {8'h00, m_gpo_a}, {8'h00, gpo_a});
        check_pins({name, " gpd_a"}, {8'h00, m_gpd_a}, {8'h00, gpd_a});
        check_pins({name, " gpo_b"}, m_gpo_b, gpo_b);
        check_pins({name, " gpd_b"}, m_gpd_b, gpd_b);
        check_level({name, " pwm"}, m_en && ( m_cnt < m_duty ), pwm);
    endtask

    // watchdog
    initial
    begin
        repeat( TIMEOUT_CYCLES ) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [31 : 0] r;
        logic [31 : 0] wd;
        logic [3 : 0]  sel;
        logic [3 : 0]  ofs;
        logic [15 : 0] per;
        logic [15 : 0] dut;
        logic          w;
        resetn     = 1'b0;
        bus        = '0;
        gpi_a      = '0;
        gpi_b      = '0;
        pin_a_next = '0;
        pin_b_next = '0;
        lfsr_state = 32'h59fa;
        err_count  = 0;
        m_gpo_a    = '0;
        m_gpd_a    = '0;
        m_sa1      = '0;
        m_sa2      = '0;
        m_gpo_b    = '0;
        m_gpd_b    = '0;
        m_sb1      = '0;
        m_sb2      = '0;
        m_period   = '0;
        m_duty     = '0;
        m_cnt      = '0;
        m_en       = 1'b0;
        pend_we    = 1'b0;
        pend_addr  = '0;
        pend_wd    = '0;
        repeat( RESET_CYCLES ) @(posedge clk);
        resetn <= 1'b1;

        // 1: reset values, pins low
        do_access("reset idle", make_addr(4'd0, 4'd0), 1'b0, '0);
        do_access("reset idle", make_addr(4'd1, 4'd0), 1'b0, '0);
        for( int s = 0; s < 3; s++ )
            for( int o = 0; o < 4; o++ )
            begin
                do_access("reset read", make_addr(s[3 : 0], o[1 : 0] * 4'd4), 1'b0, '0);
                check_word("reset zero", 32'h0, rd);
            end

        // 2: gpo and dir writes, sometimes a pwm write in between
        for( int i = 0; i < N_GPIO_WR; i++ )
        begin
            r   = rand_bits(3);
            sel = r[2 : 1] == 2'd0 ? bus_pkg::SEL_PWM : {3'b000, r[0]};
            r   = rand_bits(1);
            ofs = r[0] ? periph_regs_pkg::GPIO_DIR : periph_regs_pkg::GPIO_GPO;
            wd  = rand_bits(32);
            if( sel == bus_pkg::SEL_PWM )
            begin
                ofs = periph_regs_pkg::PWM_DUTY;
                wd  = wd & 32'h0000_003f;   // duty only, pwm stays off
            end
            do_access("gpio write", make_addr(sel, ofs), 1'b1, wd);
            do_access("gpio readback", make_addr(sel, ofs), 1'b0, '0);
        end

        // 3: input pins through the synchronizer
        for( int i = 0; i < N_GPI; i++ )
        begin
            r = rand_bits(8);
            pin_a_next = r[7 : 0];
            r = rand_bits(16);
            pin_b_next = r[15 : 0];
            repeat( 3 ) do_access("gpi settle", make_addr(4'd0, 4'd0), 1'b0, '0);
            do_access("gpi a", make_addr(4'd0, periph_regs_pkg::GPIO_GPI), 1'b0, '0);
            check_word("gpi a value", {24'h0, pin_a_next}, rd);
            do_access("gpi b", make_addr(4'd1, periph_regs_pkg::GPIO_GPI), 1'b0, '0);
            check_word("gpi b value", {16'h0, pin_b_next}, rd);
            r   = rand_bits(4);
            ofs = ( r[3 : 0] == 4'd0 || r[3 : 0] == 4'd4 || r[3 : 0] == 4'd8 )
                ? r[3 : 0] | 4'd1 : r[3 : 0];   // mapped offsets moved off the map
            do_access("gpi a unknown", make_addr(4'd0, ofs), 1'b0, '0);
            check_word("gpi a unknown value", {24'h0, pin_a_next}, rd);
            do_access("gpi b unknown", make_addr(4'd1, ofs), 1'b0, '0);
            check_word("gpi b unknown value", {16'h0, pin_b_next}, rd);
        end

        // 4: unmapped selects
        for( int i = 0; i < N_UNMAP; i++ )
        begin
            r   = rand_bits(4);
            sel = r[3 : 0] < 4'd3 ? r[3 : 0] + 4'd3 : r[3 : 0];
            r   = rand_bits(4);
            ofs = r[3 : 0];
            wd  = rand_bits(32);
            do_access("unmapped write", make_addr(sel, ofs), 1'b1, wd);
            check_word("unmapped write rd", 32'h0, rd);
            do_access("unmapped read", make_addr(sel, ofs), 1'b0, '0);
            check_word("unmapped read rd", 32'h0, rd);
        end

        // 5: pwm run then stop
        r   = rand_bits(5);
        per = 16'd8 + {11'h000, r[4 : 0]};
        r   = rand_bits(6);
        dut = {10'h000, r[5 : 0]};
        do_access("pwm period", make_addr(bus_pkg::SEL_PWM, periph_regs_pkg::PWM_PERIOD),
                  1'b1, {16'h0, per});
        do_access("pwm duty", make_addr(bus_pkg::SEL_PWM, periph_regs_pkg::PWM_DUTY),
                  1'b1, {16'h0, dut});
        do_access("pwm enable", make_addr(bus_pkg::SEL_PWM, periph_regs_pkg::PWM_CTRL),
                  1'b1, 32'h1);
        repeat( N_PWM )
            do_access("pwm run", make_addr(bus_pkg::SEL_PWM, periph_regs_pkg::PWM_CNT), 1'b0, '0);
        do_access("pwm disable", make_addr(bus_pkg::SEL_PWM, periph_regs_pkg::PWM_CTRL),
                  1'b1, 32'h0);
        repeat( 4 )
            do_access("pwm off", make_addr(bus_pkg::SEL_PWM, periph_regs_pkg::PWM_CNT), 1'b0, '0);
        check_word("pwm off cnt", 32'h0, rd);
        check_level("pwm off level", 1'b0, pwm);

        // 6: mixed traffic, sel 3 is unmapped
        for( int i = 0; i < N_MIX; i++ )
        begin
            r   = rand_bits(2);
            sel = {2'b00, r[1 : 0]};
            r   = rand_bits(3);
            if( r[2 : 0] == 3'd0 )
            begin
                r   = rand_bits(4);
                ofs = r[3 : 0];
            end
            else
            begin
                r   = rand_bits(2);
                ofs = {r[1 : 0], 2'b00};
            end
            r  = rand_bits(1);
            w  = r[0];
            wd = rand_bits(32);
            if( sel == bus_pkg::SEL_PWM && ofs == periph_regs_pkg::PWM_PERIOD )
                wd = wd & 32'h0000_003f;    // short periods so the counter wraps
            r = rand_bits(3);
            if( r[2 : 0] == 3'd0 )
            begin
                r = rand_bits(8);
                pin_a_next = r[7 : 0];
                r = rand_bits(16);
                pin_b_next = r[15 : 0];
            end
            do_access("mixed", make_addr(sel, ofs), w, wd);
        end

        if( err_count == 0 )
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule : tb_periph_top

`default_nettype wire

//--- testbench/periph_chk.sv
// ############################
// bound into periph_top
// enable is shadowed from ctrl writes
// ############################
`default_nettype none

module periph_chk
#(
    parameter int GPIO_A_W = 8,
    parameter int GPIO_B_W = 16
)(
    input   logic                       clk,
    input   logic                       resetn,
    input   bus_pkg::bus_req_t          req_gpio_a_i,   // router outputs
    input   bus_pkg::bus_req_t          req_gpio_b_i,
    input   bus_pkg::bus_req_t          req_pwm_i,
    input   logic   [GPIO_A_W-1 : 0]    gpo_a_i,
    input   logic   [GPIO_A_W-1 : 0]    gpd_a_i,
    input   logic   [GPIO_B_W-1 : 0]    gpo_b_i,
    input   logic   [GPIO_B_W-1 : 0]    gpd_b_i,
    input   logic                       pwm_i
);

    logic   en_s;       // copy of pwm enable
    logic   seen_edge;  // skips the very first edge

    always_ff @(posedge clk, negedge resetn)
    begin
        if( !resetn )
            en_s <= 1'b0;
        else if( req_pwm_i.we && req_pwm_i.addr[3 : 0] == periph_regs_pkg::PWM_CTRL )
            en_s <= req_pwm_i.wd[0];
    end

    always_ff @(posedge clk)
        seen_edge <= 1'b1;

    a_one_we : assert property ( @(posedge clk) disable iff ( !resetn )
        $onehot0({req_gpio_a_i.we, req_gpio_b_i.we, req_pwm_i.we}) )
        else $error("more than one slave write strobe");

    a_gpo_a_hold : assert property ( @(posedge clk) disable iff ( !resetn )
        !$past(req_gpio_a_i.we) |-> $stable(gpo_a_i) )
        else $error("gpo_a changed without a write");

    a_pwm_off : assert property ( @(posedge clk) disable iff ( !resetn )
        !en_s |-> !pwm_i )
        else $error("pwm high while disabled");

    a_reset_pins : assert property ( @(posedge clk)
        ( !resetn && seen_edge ) |-> ( gpo_a_i == '0 && gpd_a_i == '0
                                       && gpo_b_i == '0 && gpd_b_i == '0 ) )
        else $error("gpio outputs not zero in reset");

endmodule : periph_chk

bind periph_top periph_chk
#(
    .GPIO_A_W   ( GPIO_A_W  ),
    .GPIO_B_W   ( GPIO_B_W  )
)
chk_0
(
    .clk            ( clk           ),
    .resetn         ( resetn        ),
    .req_gpio_a_i   ( req_gpio_a    ),
    .req_gpio_b_i   ( req_gpio_b    ),
    .req_pwm_i      ( req_pwm       ),
    .gpo_a_i        ( gpo_a_o       ),
    .gpd_a_i        ( gpd_a_o       ),
    .gpo_b_i        ( gpo_b_o       ),
    .gpd_b_i        ( gpd_b_o       ),
    .pwm_i          ( pwm_o         )
);

`default_nettype wire

//--- rtl/periph_top.sv
// ############################
// gpio a at select 0, gpio b at 1, pwm at 2
// one access per clock, no stalls
// ############################
`default_nettype none

module periph_top
#(
    parameter int GPIO_A_W = 8,
    parameter int GPIO_B_W = 16
)(
    input   logic                       clk,
    input   logic                       resetn,
    // master
    input   bus_pkg::bus_req_t          bus_i,
    output  logic   [31 : 0]            rd_o,
    // gpio a pins
    input   logic   [GPIO_A_W-1 : 0]    gpi_a_i,
    output  logic   [GPIO_A_W-1 : 0]    gpo_a_o,
    output  logic   [GPIO_A_W-1 : 0]    gpd_a_o,
    // gpio b pins
    input   logic   [GPIO_B_W-1 : 0]    gpi_b_i,
    output  logic   [GPIO_B_W-1 : 0]    gpo_b_o,
    output  logic   [GPIO_B_W-1 : 0]    gpd_b_o,
    // pwm
    output  logic                       pwm_o
);

    bus_pkg::bus_req_t  req_gpio_a;     // per-slave requests
    bus_pkg::bus_req_t  req_gpio_b;
    bus_pkg::bus_req_t  req_pwm;
    logic   [31 : 0]    rd_gpio_a;      // per-slave read data
    logic   [31 : 0]    rd_gpio_b;
    logic   [31 : 0]    rd_pwm;

    periph_router router_0
    (
        .bus_i          ( bus_i         ),
        .rd_o           ( rd_o          ),
        .req_gpio_a_o   ( req_gpio_a    ),
        .req_gpio_b_o   ( req_gpio_b    ),
        .req_pwm_o      ( req_pwm       ),
        .rd_gpio_a_i    ( rd_gpio_a     ),
        .rd_gpio_b_i    ( rd_gpio_b     ),
        .rd_pwm_i       ( rd_pwm        )
    );

    gpio_port #( .GPIO_W ( GPIO_A_W ) ) gpio_a
    (
        .clk    ( clk       ), .resetn ( resetn    ),
        .req_i  ( req_gpio_a), .rd_o   ( rd_gpio_a ),
        .gpi_i  ( gpi_a_i   ), .gpo_o  ( gpo_a_o   ), .gpd_o ( gpd_a_o )
    );

    gpio_port #( .GPIO_W ( GPIO_B_W ) ) gpio_b
    (
        .clk    ( clk       ), .resetn ( resetn    ),
        .req_i  ( req_gpio_b), .rd_o   ( rd_gpio_b ),
        .gpi_i  ( gpi_b_i   ), .gpo_o  ( gpo_b_o   ), .gpd_o ( gpd_b_o )
    );

    pwm_gen pwm_0
    (
        .clk    ( clk       ),
        .resetn ( resetn    ),
        .req_i  ( req_pwm   ),
        .rd_o   ( rd_pwm    ),
        .pwm_o  ( pwm_o     )
    );

endmodule : periph_top

`default_nettype wire

//--- rtl/periph_router.sv
// ############################
// purely combinational decode
// unmapped selects read zero, writes dropped
// ############################
`default_nettype none

module periph_router
(
    // master side
    input   bus_pkg::bus_req_t      bus_i,          // request from master
    output  logic   [31 : 0]        rd_o,           // read data to master
    // slave side
    output  bus_pkg::bus_req_t      req_gpio_a_o,
    output  bus_pkg::bus_req_t      req_gpio_b_o,
    output  bus_pkg::bus_req_t      req_pwm_o,
    input   logic   [31 : 0]        rd_gpio_a_i,
    input   logic   [31 : 0]        rd_gpio_b_i,
    input   logic   [31 : 0]        rd_pwm_i
);

    logic   [bus_pkg::SEL_W-1 : 0]  sel;        // select field from addr
    logic                           hit_gpio_a; // one-hot selects
    logic                           hit_gpio_b;
    logic                           hit_pwm;

    assign sel = bus_i.addr[bus_pkg::SEL_LSB +: bus_pkg::SEL_W];

    assign hit_gpio_a = ( sel == bus_pkg::SEL_GPIO_A );
    assign hit_gpio_b = ( sel == bus_pkg::SEL_GPIO_B );
    assign hit_pwm    = ( sel == bus_pkg::SEL_PWM    );

    // same addr and wd everywhere, only we is steered
    always_comb
    begin
        req_gpio_a_o    = bus_i;
        req_gpio_b_o    = bus_i;
        req_pwm_o       = bus_i;
        req_gpio_a_o.we = bus_i.we && hit_gpio_a;
        req_gpio_b_o.we = bus_i.we && hit_gpio_b;
        req_pwm_o.we    = bus_i.we && hit_pwm;
    end

    // read data mux
    always_comb
    begin
        rd_o = '0;  // unmapped
        case( sel )
            bus_pkg::SEL_GPIO_A :   rd_o = rd_gpio_a_i;
            bus_pkg::SEL_GPIO_B :   rd_o = rd_gpio_b_i;
            bus_pkg::SEL_PWM    :   rd_o = rd_pwm_i;
            default             :   rd_o = '0;
        endcase
    end

endmodule : periph_router

`default_nettype wire

//--- rtl/pwm_gen.sv
// ############################
// counter runs 0..period, so period+1 clocks
// duty > period keeps pwm_o high
// CNT register is read only
// ############################
`default_nettype none

module pwm_gen
(
    input   logic                   clk,
    input   logic                   resetn,
    // router side
    input   bus_pkg::bus_req_t      req_i,
    output  logic   [31 : 0]        rd_o,
    // pwm output
    output  logic                   pwm_o
);

    localparam int CW = periph_regs_pkg::PWM_CNT_W;

    logic   [bus_pkg::OFS_W-1 : 0]  ofs;
    logic   [CW-1 : 0]              period_r;
    logic   [CW-1 : 0]              duty_r;
    logic                           en_r;
    logic   [CW-1 : 0]              cnt;
    logic                           period_we;
    logic                           duty_we;
    logic                           ctrl_we;

    assign ofs       = req_i.addr[bus_pkg::OFS_W-1 : 0];
    assign period_we = req_i.we && ( ofs == periph_regs_pkg::PWM_PERIOD );
    assign duty_we   = req_i.we && ( ofs == periph_regs_pkg::PWM_DUTY   );
    assign ctrl_we   = req_i.we && ( ofs == periph_regs_pkg::PWM_CTRL   );

    // config registers
    always_ff @(posedge clk, negedge resetn)
    begin
        if( !resetn )
        begin
            period_r <= periph_regs_pkg::PWM_PERIOD_RST;
            duty_r   <= periph_regs_pkg::PWM_DUTY_RST;
            en_r     <= periph_regs_pkg::PWM_EN_RST;
        end
        else
        begin
            if( period_we )
                period_r <= req_i.wd[CW-1 : 0];
            if( duty_we )
                duty_r   <= req_i.wd[CW-1 : 0];
            if( ctrl_we )
                en_r     <= req_i.wd[periph_regs_pkg::PWM_EN_BIT];
        end
    end

    // counter, held at zero while disabled
    always_ff @(posedge clk, negedge resetn)
    begin
        if( !resetn )
            cnt <= '0;
        else if( !en_r )
            cnt <= '0;
        else if( cnt >= period_r )  // also catches period lowered below cnt
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // compare on live registers
    assign pwm_o = en_r && ( cnt < duty_r );

    always_comb
    begin
        rd_o = '0;
        case( ofs )
            periph_regs_pkg::PWM_PERIOD : rd_o[CW-1 : 0] = period_r;
            periph_regs_pkg::PWM_DUTY   : rd_o[CW-1 : 0] = duty_r;
            periph_regs_pkg::PWM_CTRL   : rd_o[periph_regs_pkg::PWM_EN_BIT] = en_r;
            periph_regs_pkg::PWM_CNT    : rd_o[CW-1 : 0] = cnt;
            default                     : rd_o = '0;   // hole in the map
        endcase
    end

endmodule : pwm_gen

`default_nettype wire

//--- rtl/gpio_port.sv
// ############################
// GPIO_W up to 32, wd truncated to port width
// gpi reads lag the pins by two clocks
// direction is a plain output level, no pads here
// ############################
`default_nettype none

module gpio_port
#(
    parameter int GPIO_W = 8
)(
    input   logic                   clk,
    input   logic                   resetn,
    // router side
    input   bus_pkg::bus_req_t      req_i,  // decoded request
    output  logic   [31 : 0]        rd_o,   // read data
    // pin side
    input   logic   [GPIO_W-1 : 0]  gpi_i,  // async input pins
    output  logic   [GPIO_W-1 : 0]  gpo_o,  // output levels
    output  logic   [GPIO_W-1 : 0]  gpd_o   // direction levels
);

    logic   [bus_pkg::OFS_W-1 : 0]  ofs;        // register offset
    logic   [GPIO_W-1 : 0]          gpi_s;      // synchronized inputs
    logic   [GPIO_W-1 : 0]          gpo_r;
    logic   [GPIO_W-1 : 0]          gpd_r;
    logic                           gpo_we;
    logic                           gpd_we;

    assign ofs = req_i.addr[bus_pkg::OFS_W-1 : 0];

    // input pins never reach rd_o unsynchronized
    gpi_sync
    #(
        .WIDTH      ( GPIO_W    )
    )
    gpi_sync_0
    (
        .clk        ( clk       ),
        .resetn     ( resetn    ),
        .async_i    ( gpi_i     ),
        .sync_o     ( gpi_s     )
    );

    assign gpo_we = req_i.we && ( ofs == periph_regs_pkg::GPIO_GPO );
    assign gpd_we = req_i.we && ( ofs == periph_regs_pkg::GPIO_DIR );

    always_ff @(posedge clk, negedge resetn)
    begin
        if( !resetn )
            gpo_r <= periph_regs_pkg::GPIO_GPO_RST[GPIO_W-1 : 0];
        else if( gpo_we )
            gpo_r <= req_i.wd[GPIO_W-1 : 0];    // low bits only
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if( !resetn )
            gpd_r <= periph_regs_pkg::GPIO_DIR_RST[GPIO_W-1 : 0];
        else if( gpd_we )
            gpd_r <= req_i.wd[GPIO_W-1 : 0];
    end

    // readback, zero-extended
    always_comb
    begin
        rd_o = '0;
        case( ofs )
            periph_regs_pkg::GPIO_GPO : rd_o[GPIO_W-1 : 0] = gpo_r;
            periph_regs_pkg::GPIO_DIR : rd_o[GPIO_W-1 : 0] = gpd_r;
            default                   : rd_o[GPIO_W-1 : 0] = gpi_s;  // GPI and unknown
        endcase
    end

    assign gpo_o = gpo_r;
    assign gpd_o = gpd_r;

endmodule : gpio_port

`default_nettype wire

//--- rtl/gpi_sync.sv
// ############################
// per-bit two-flop synchronizer
// no glitch filter, bits may land a clock apart
// ############################
`default_nettype none

module gpi_sync
#(
    parameter int WIDTH = 8
)(
    input   logic                   clk,
    input   logic                   resetn,
    input   logic   [WIDTH-1 : 0]   async_i,    // raw pins
    output  logic   [WIDTH-1 : 0]   sync_o      // safe to read
);

    logic   [WIDTH-1 : 0]   meta;   // first stage, may go metastable
    logic   [WIDTH-1 : 0]   stable; // second stage

    always_ff @(posedge clk, negedge resetn)
    begin
        if( !resetn )
        begin
            meta   <= '0;
            stable <= '0;
        end
        else
        begin
            meta   <= async_i;
            stable <= meta;
        end
    end

    assign sync_o = stable;

endmodule : gpi_sync

`default_nettype wire

//--- rtl/periph_regs_pkg.sv
// ############################
// register map of gpio and pwm slaves
// all registers reset to zero
// ############################
`default_nettype none

package periph_regs_pkg;

    // gpio register offsets
    localparam logic [3 : 0] GPIO_GPI = 4'h0;  // synchronized pins, read only
    localparam logic [3 : 0] GPIO_GPO = 4'h4;  // output level
    localparam logic [3 : 0] GPIO_DIR = 4'h8;  // direction level

    // pwm register offsets
    localparam logic [3 : 0] PWM_PERIOD = 4'h0;
    localparam logic [3 : 0] PWM_DUTY   = 4'h4;
    localparam logic [3 : 0] PWM_CTRL   = 4'h8;  // bit 0 enable
    localparam logic [3 : 0] PWM_CNT    = 4'hc;  // live counter, read only

    // pwm counter and compare width
    localparam int PWM_CNT_W = 16;

    // control register bit positions
    localparam int PWM_EN_BIT = 0;

    // reset values
    localparam logic [31 : 0] GPIO_GPO_RST = '0;
    localparam logic [31 : 0] GPIO_DIR_RST = '0;

    localparam logic [PWM_CNT_W-1 : 0] PWM_PERIOD_RST = '0;
    localparam logic [PWM_CNT_W-1 : 0] PWM_DUTY_RST   = '0;
    localparam logic                   PWM_EN_RST     = 1'b0;

endpackage : periph_regs_pkg

`default_nettype wire

//--- rtl/bus_pkg.sv
// ############################
// single-cycle word bus, no wait states
// slave select in addr[11:8], offset in addr[3:0]
// ############################
`default_nettype none

package bus_pkg;

    // request from the master, one word per cycle
    typedef struct packed
    {
        logic   [31 : 0]    addr;   // byte address
        logic               we;     // write strobe
        logic   [31 : 0]    wd;     // write data
    } bus_req_t;

    // slave select field
    localparam int SEL_LSB = 8;
    localparam int SEL_W   = 4;

    // select codes
    localparam logic [SEL_W-1 : 0] SEL_GPIO_A = 4'd0;
    localparam logic [SEL_W-1 : 0] SEL_GPIO_B = 4'd1;
    localparam logic [SEL_W-1 : 0] SEL_PWM    = 4'd2;
    // codes 3..15 unmapped, read as zero

    // register offset inside a slave
    localparam int OFS_W = 4;   // addr[3:0]

endpackage : bus_pkg

`default_nettype wire
